// ==== Bender.yml ====
package:
  name: board_top

sources:
  - include_dirs:
      - hw
    files:
      - hw/board_io_pkg.sv
      - hw/audio_pkg.sv
      - hw/slow_tick_gen.sv
      - hw/inmp441_mic_i2s_receiver.sv
      - hw/tm1638_board_controller.sv
      - hw/lab_top.sv
      - hw/board_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/board_top_tb.sv

// ==== hw/audio_pkg.sv ====
`default_nettype none

`include "board_macros.svh"

package audio_pkg;

    // Two's-complement microphone sample
    typedef logic [`MIC_W_SAMPLE - 1:0] mic_sample_t;

    // I2S left-channel capture
    typedef enum logic [1:0]
    {
        I2S_WAIT_WS,   // Wait for ws to fall
        I2S_SKIP,      // First sck after ws carries no data
        I2S_SHIFT,     // Shift in the sample bits
        I2S_DONE       // Hand the sample over
    } i2s_state_t;

endpackage

`default_nettype wire

// ==== hw/board_io_pkg.sv ====
`default_nettype none

`include "board_macros.svh"

package board_io_pkg;

    typedef logic [`TM_W_KEY   - 1:0] panel_key_t;   // Pressed keys, active high
    typedef logic [`TM_W_LED   - 1:0] panel_led_t;   // Panel LEDs, lit when set
    typedef logic [`TM_W_DIGIT - 1:0] digit_sel_t;   // One enable per digit

    // One digit's segments. Lab order is a..g then the dot, a at the MSB;
    // the panel expects the reverse bit order
    typedef logic [7:0] seg_t;

    // Everything the lab block puts on the front panel
    typedef struct packed
    {
        panel_led_t                  led;
        seg_t [`TM_W_DIGIT - 1:0]    seg;   // seg[0] is digit 0
    } panel_disp_t;

    // Panel serial sequencer, one state per sio_clk half period
    typedef enum logic [2:0]
    {
        TM_IDLE,       // Strobe high, display snapshot at the end
        TM_STB_LOW,    // Strobe low before the first bit
        TM_CLK_LOW,    // Data changes
        TM_CLK_HIGH,   // Data sampled
        TM_STB_HIGH    // Gap between transactions
    } tm_state_t;

endpackage

`default_nettype wire

// ==== hw/board_macros.svh ====
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// ----------------------------------------
// Clocking
// ----------------------------------------

`define BOARD_CLK_MHZ  25   // System clock in MHz
`define BOARD_TICK_HZ  1    // Slow tick rate

// ----------------------------------------
// TM1638 front panel
// ----------------------------------------

`define TM_W_KEY       8    // Panel keys
`define TM_W_LED       8    // Panel LEDs
`define TM_W_DIGIT     8    // Seven-segment digits
`define TM_SIO_DIV     12   // Clocks per sio_clk half period at BOARD_CLK_MHZ

// ----------------------------------------
// INMP441 microphone
// ----------------------------------------

`define I2S_SCK_DIV    4    // Clocks per sck half period
`define MIC_W_SAMPLE   24   // Sample width

`endif

// ==== hw/board_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "board_macros.svh"

module board_top
    import board_io_pkg::*, audio_pkg::*;
#(
    parameter int clk_mhz = `BOARD_CLK_MHZ,
    parameter int tick_hz = `BOARD_TICK_HZ
)
(
    input  logic        clk,
    input  logic [1:0]  key,       // Active low, key[1] is reset
    input  logic        uart_rx,
    output logic        uart_tx,
    output logic [5:0]  led,       // Active low
    inout  wire  [22:0] gpio
);

    logic                     rst;
    logic                     tick;
    logic                     mic_valid;
    mic_sample_t              mic;
    panel_key_t               tm_keys;
    panel_key_t               lab_keys;
    panel_disp_t              disp;
    digit_sel_t               digit;
    seg_t [`TM_W_DIGIT - 1:0] hgfedcba;

    // Board button or the last panel key
    always_ff @(posedge clk)
        rst <= ~key[1] | tm_keys[`TM_W_KEY - 1];

    assign lab_keys = {1'b0, tm_keys[`TM_W_KEY - 2:0]};
    assign led      = ~disp.led[5:0];
    assign uart_tx  = 1'b1;                      // Line idle

    // Panel wants segment bits in the opposite order
    always_comb
    begin
        for (int d = 0; d < `TM_W_DIGIT; d++)
            for (int i = 0; i < 8; i++)
                hgfedcba[d][i] = disp.seg[d][7 - i];
    end

    // ----------------------------------------

    slow_tick_gen #(.clk_mhz (clk_mhz), .tick_hz (tick_hz)) i_tick
    (
        .clk  ( clk  ),
        .rst  ( rst  ),
        .tick ( tick )
    );

    lab_top i_lab_top
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .tick      ( tick      ),
        .key       ( lab_keys  ),
        .mic       ( mic       ),
        .mic_valid ( mic_valid ),
        .disp      ( disp      ),
        .digit     ( digit     )
    );

    tm1638_board_controller #(.clk_mhz (clk_mhz)) i_tm1638
    (
        .clk      ( clk       ),
        .rst      ( rst       ),
        .hgfedcba ( hgfedcba  ),
        .digit    ( digit     ),
        .ledr     ( disp.led  ),
        .keys     ( tm_keys   ),
        .sio_clk  ( gpio[15]  ),
        .sio_stb  ( gpio[14]  ),
        .sio_data ( gpio[16]  )
    );

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk         ( clk       ),
        .rst         ( rst       ),
        .lr          ( gpio[18]  ),
        .ws          ( gpio[19]  ),
        .sck         ( gpio[20]  ),
        .sd          ( gpio[17]  ),
        .value       ( mic       ),
        .value_valid ( mic_valid )
    );

    // ----------------------------------------

    assign gpio[21]   = 1'b0;                    // Microphone ground
    assign gpio[22]   = 1'b1;                    // Microphone supply
    assign gpio[13:0] = {14{1'bz}};

endmodule

`default_nettype wire

// ==== hw/inmp441_mic_i2s_receiver.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "board_macros.svh"

module inmp441_mic_i2s_receiver
    import audio_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    output logic        lr,
    output logic        ws,
    output logic        sck,
    input  logic        sd,
    output mic_sample_t value,
    output logic        value_valid
);

    localparam int w_pre = (`I2S_SCK_DIV > 1) ? $clog2(`I2S_SCK_DIV) : 1;
    localparam int w_n   = $clog2(`MIC_W_SAMPLE);

    logic [w_pre - 1:0] pre_cnt;
    logic               pre_end;
    logic               sck_rise;
    logic               sck_fall;
    logic [5:0]         bit_cnt;    // Position in the 64-bit ws frame
    logic [w_n - 1:0]   n_bits;
    mic_sample_t        shifter;
    i2s_state_t         state;

    assign lr = 1'b0;               // Microphone answers in the left slot
    assign ws = bit_cnt[5];         // Low for the left half-frame

    // ----------------------------------------
    // sck and ws generation
    // ----------------------------------------

    assign pre_end  = (pre_cnt == w_pre'(`I2S_SCK_DIV - 1));
    assign sck_rise = pre_end & ~sck;
    assign sck_fall = pre_end &  sck;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pre_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            pre_cnt <= pre_end ? '0 : pre_cnt + 1'b1;
            if (pre_end)
                sck <= ~sck;
            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;   // ws moves on sck falling edges
        end
    end

    // ----------------------------------------
    // Left-channel capture
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state       <= I2S_WAIT_WS;
            n_bits      <= '0;
            value       <= '0;
            value_valid <= 1'b0;
        end
        else
        begin
            value_valid <= 1'b0;
            case (state)
                I2S_WAIT_WS:
                    if (sck_fall && bit_cnt == 6'd63)   // ws about to fall
                        state <= I2S_SKIP;
                I2S_SKIP:
                    if (sck_rise)
                    begin
                        n_bits <= '0;
                        state  <= I2S_SHIFT;
                    end
                I2S_SHIFT:
                    if (sck_rise)
                    begin
                        n_bits <= n_bits + 1'b1;
                        if (n_bits == w_n'(`MIC_W_SAMPLE - 1))
                            state <= I2S_DONE;
                    end
                I2S_DONE:
                begin
                    value       <= shifter;
                    value_valid <= 1'b1;
                    state       <= I2S_WAIT_WS;
                end
                default:
                    state <= I2S_WAIT_WS;
            endcase
        end
    end

    // MSB arrives first
    always_ff @(posedge clk)
    begin
        if (state == I2S_SHIFT && sck_rise)
            shifter <= {shifter[`MIC_W_SAMPLE - 2:0], sd};
    end

endmodule

`default_nettype wire

// ==== hw/lab_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module lab_top
    import board_io_pkg::*, audio_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        tick,
    input  panel_key_t  key,
    input  mic_sample_t mic,
    input  logic        mic_valid,
    output panel_disp_t disp,
    output digit_sel_t  digit
);

    mic_sample_t sample_q;

    // a..g then dot, a at the MSB
    function automatic seg_t hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0: hex_to_seg = 8'hFC;
            4'h1: hex_to_seg = 8'h60;
            4'h2: hex_to_seg = 8'hDA;
            4'h3: hex_to_seg = 8'hF2;
            4'h4: hex_to_seg = 8'h66;
            4'h5: hex_to_seg = 8'hB6;
            4'h6: hex_to_seg = 8'hBE;
            4'h7: hex_to_seg = 8'hE0;
            4'h8: hex_to_seg = 8'hFE;
            4'h9: hex_to_seg = 8'hF6;
            4'hA: hex_to_seg = 8'hEE;
            4'hB: hex_to_seg = 8'h3E;
            4'hC: hex_to_seg = 8'h9C;
            4'hD: hex_to_seg = 8'h7A;
            4'hE: hex_to_seg = 8'h9E;
            default: hex_to_seg = 8'h8E;
        endcase
    endfunction

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            sample_q <= '0;
            disp     <= '0;
            digit    <= '0;
        end
        else
        begin
            if (mic_valid)
                sample_q <= mic;                       // Keep the latest sample

            disp.led[6:0] <= key[6:0];                 // Keys mirrored
            disp.led[7]   <= disp.led[7] ^ tick;       // Heartbeat

            for (int n = 0; n < 6; n++)
                disp.seg[n] <= hex_to_seg(sample_q[4 * n +: 4]);
            disp.seg[7] <= '0;                         // Unused digits stay dark
            disp.seg[6] <= '0;

            digit <= 8'b0011_1111;
        end
    end

endmodule

`default_nettype wire

// ==== hw/slow_tick_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "board_macros.svh"

module slow_tick_gen
#(
    parameter int clk_mhz = `BOARD_CLK_MHZ,
    parameter int tick_hz = `BOARD_TICK_HZ
)
(
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int period = clk_mhz * 1000000 / tick_hz;   // Clocks per tick
    localparam int w_cnt  = (period > 1) ? $clog2(period) : 1;

    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt  <= w_cnt'(period - 1);
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= w_cnt'(period - 1);   // Reload at terminal count
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/tm1638_board_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "board_macros.svh"

module tm1638_board_controller
    import board_io_pkg::*;
#(
    parameter int clk_mhz = `BOARD_CLK_MHZ
)
(
    input  logic                     clk,
    input  logic                     rst,
    input  seg_t [`TM_W_DIGIT - 1:0] hgfedcba,
    input  digit_sel_t               digit,
    input  panel_led_t               ledr,
    output panel_key_t               keys,
    output logic                     sio_clk,
    output logic                     sio_stb,
    inout  wire                      sio_data
);

    localparam int half_raw = `TM_SIO_DIV * clk_mhz / `BOARD_CLK_MHZ;
    localparam int half_div = (half_raw < 1) ? 1 : half_raw;
    localparam int w_div    = (half_div > 1) ? $clog2(half_div) : 1;

    logic [w_div - 1:0]        div_cnt;
    logic                      half_end;
    tm_state_t                 state;
    logic [1:0]                txn;         // 0 mode, 1 data, 2 display on, 3 key read
    logic [4:0]                byte_idx;
    logic [4:0]                byte_last;
    logic [4:0]                next_idx;
    logic [3:0]                pos;
    logic [2:0]                bit_idx;
    logic [7:0]                shreg;
    logic [7:0]                byte_next;
    logic                      reading;
    logic                      sio_oe;
    logic                      keys_load;
    seg_t [`TM_W_DIGIT - 1:0]  seg_q;
    digit_sel_t                dig_q;
    panel_led_t                led_q;
    logic [3:0][7:0]           key_bytes;

    // ----------------------------------------
    // Half-period timer
    // ----------------------------------------

    assign half_end = (div_cnt == w_div'(half_div - 1));

    always_ff @(posedge clk)
    begin
        if (rst || half_end)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // ----------------------------------------
    // Byte source
    // ----------------------------------------

    assign byte_last = (txn == 2'd1) ? 5'd16 : (txn == 2'd3) ? 5'd4 : 5'd0;
    assign next_idx  = (state == TM_STB_LOW) ? 5'd0 : byte_idx + 5'd1;
    assign pos       = 4'(next_idx - 5'd1);   // Digit/LED pair after the address
    assign reading   = (txn == 2'd3) && (byte_idx != 5'd0);

    always_comb
    begin
        case (txn)
            2'd0: byte_next = 8'h40;               // Write, auto increment
            2'd1:
            begin
                if (next_idx == 5'd0)
                    byte_next = 8'hC0;             // Start address
                else if (!pos[0])
                    byte_next = dig_q[pos[3:1]] ? seg_q[pos[3:1]] : 8'h00;
                else
                    byte_next = {7'b0, led_q[pos[3:1]]};
            end
            2'd2: byte_next = 8'h8F;               // Display on, full brightness
            default: byte_next = (next_idx == 5'd0) ? 8'h42 : 8'h00;
        endcase
    end

    // ----------------------------------------
    // Sequencer
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= TM_IDLE;
            txn       <= '0;
            byte_idx  <= '0;
            bit_idx   <= '0;
            keys_load <= 1'b0;
        end
        else
        begin
            keys_load <= 1'b0;
            if (half_end)
            begin
                case (state)
                    TM_IDLE:
                    begin
                        txn      <= 2'd0;
                        byte_idx <= '0;
                        state    <= TM_STB_LOW;
                    end
                    TM_STB_LOW:
                    begin
                        bit_idx <= '0;
                        state   <= TM_CLK_LOW;
                    end
                    TM_CLK_LOW:
                        state <= TM_CLK_HIGH;
                    TM_CLK_HIGH:
                    begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx != 3'd7)
                            state <= TM_CLK_LOW;
                        else if (byte_idx == byte_last)
                        begin
                            keys_load <= reading;   // Last key byte is in
                            state     <= TM_STB_HIGH;
                        end
                        else
                        begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= TM_CLK_LOW;
                        end
                    end
                    TM_STB_HIGH:
                        if (txn == 2'd3)
                            state <= TM_IDLE;
                        else
                        begin
                            txn      <= txn + 1'b1;
                            byte_idx <= '0;
                            state    <= TM_STB_LOW;
                        end
                    default:
                        state <= TM_IDLE;
                endcase
            end
        end
    end

    // Shifter, LSB first out and in
    always_ff @(posedge clk)
    begin
        if (half_end)
        begin
            if (state == TM_IDLE)
            begin
                seg_q <= hgfedcba;                 // Snapshot for this refresh
                dig_q <= digit;
                led_q <= ledr;
            end
            else if (state == TM_STB_LOW)
                shreg <= byte_next;
            else if (state == TM_CLK_HIGH)
            begin
                if (bit_idx == 3'd7)
                begin
                    if (reading)
                        key_bytes[2'(byte_idx - 5'd1)] <= {sio_data, shreg[7:1]};
                    shreg <= byte_next;
                end
                else
                    shreg <= {sio_data, shreg[7:1]};
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            keys <= '0;
        else if (keys_load)
            for (int j = 0; j < 4; j++)
            begin
                keys[j]     <= key_bytes[j][0];
                keys[j + 4] <= key_bytes[j][4];
            end
    end

    // ----------------------------------------
    // Pins
    // ----------------------------------------

    assign sio_clk  = (state != TM_CLK_LOW);
    assign sio_stb  = (state == TM_IDLE) || (state == TM_STB_HIGH);
    assign sio_oe   = ((state == TM_CLK_LOW) || (state == TM_CLK_HIGH)) && !reading;
    assign sio_data = sio_oe ? shreg[0] : 1'bz;   // Released while the panel talks

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hw
hw/board_io_pkg.sv
hw/audio_pkg.sv
hw/slow_tick_gen.sv
hw/inmp441_mic_i2s_receiver.sv
hw/tm1638_board_controller.sv
hw/lab_top.sv
hw/board_top.sv
tests/tb_clock_gen.sv
tests/board_top_tb.sv

// ==== tests/board_top_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module board_top_tb
    import board_io_pkg::*;
();

    logic             clk;
    logic [1:0]       key;
    logic             uart_rx;
    logic             uart_tx;
    logic [5:0]       led;
    tri1  [22:0]      gpio;                  // Pull-ups on the header
    logic             mic_sd;
    logic             pnl_oe;
    logic             pnl_bit;
    logic [23:0]      cur_sample;            // Sample the microphone repeats
    logic [6:0]       pkeys;                 // Panel keys 6..0 reported as pressed
    logic             press_key7;
    logic             key7_sent;
    logic [7:0]       tbytes [0:23];         // Bytes of the current transaction
    logic [7:0]       cmds [0:7];
    logic [7:0]       data [0:15];           // Last digit and LED bytes
    logic             frame_ok;
    logic             prev_ws;
    logic [6:0]       exp_keys;
    logic [23:0]      exp_sample;
    logic             check_en;
    logic             check_led;
    logic             hb_en;
    logic             timed_out;
    logic [3:0]       led7_hist;
    int               nb;
    int               cmd_n;
    int               ndata;
    int               refresh_cnt;
    int               hb_n;
    int               k;
    int               checks;
    int               errors;
    event             refresh_done;

    assign gpio[17] = mic_sd;
    assign gpio[16] = pnl_oe ? pnl_bit : 1'bz;

    tb_clock_gen #(.period_ns (40.0)) i_clk (.clk (clk));

    board_top #(.clk_mhz (25), .tick_hz (2000)) dut_i
    (
        .clk     ( clk     ),
        .key     ( key     ),
        .uart_rx ( uart_rx ),
        .uart_tx ( uart_tx ),
        .led     ( led     ),
        .gpio    ( gpio    )
    );

    // Standard gfedcba code with a at bit 0
    function automatic logic [7:0] seg_code(input logic [3:0] nib);
        logic [7:0] table_q [0:15];
        table_q = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
                    8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71};
        return table_q[nib];
    endfunction

    // Panel bytes after 0xC0 with digit n at 2n and LED n at 2n+1
    function automatic logic [15:0][7:0] expected_panel(input logic [6:0] kv,
                                                        input logic [23:0] s);
        logic [15:0][7:0] b;
        b = '0;
        for (int n = 0; n < 6; n++)
            b[2 * n] = seg_code(s[4 * n +: 4]);
        for (int n = 0; n < 7; n++)
            b[2 * n + 1] = {7'b0, kv[n]};
        return b;
    endfunction

    // ----------------------------------------
    // Microphone model
    // ----------------------------------------

    always
    begin
        @(negedge gpio[20]);
        @(posedge clk);
        k = (prev_ws && !gpio[19]) ? 0 : ((k < 40) ? k + 1 : k);   // Slot after ws fall
        prev_ws = gpio[19];
        mic_sd <= (k >= 1 && k <= 24) ? cur_sample[24 - k] : 1'b0;
    end

    // ----------------------------------------
    // TM1638 panel model
    // ----------------------------------------

    always @(negedge gpio[14])
    begin
        nb = 0;
        key7_sent = 1'b0;
    end

    always @(posedge gpio[15])
    begin
        if (gpio[14] === 1'b0 && nb < 192)
        begin
            tbytes[nb / 8][nb % 8] = gpio[16];
            nb = nb + 1;
        end
    end

    always @(negedge gpio[15])
    begin : key_drive
        int j;
        int b;
        logic v;
        j = nb / 8 - 1;
        b = nb % 8;
        if (gpio[14] === 1'b0 && nb >= 8 && tbytes[0] == 8'h42 && j < 4)
        begin
            v = (b == 0) ? pkeys[j] : (b == 4) ? ((j == 3) ? press_key7 : pkeys[j + 4]) : 1'b0;
            if (b == 4 && j == 3 && press_key7)
                key7_sent = 1'b1;
            @(posedge clk);
            pnl_oe  <= 1'b1;
            pnl_bit <= v;
        end
    end

    always @(posedge gpio[14])
    begin
        if (nb >= 8)
        begin
            if (tbytes[0] == 8'h40)
                cmd_n = 0;                   // New refresh
            if (cmd_n < 8)
                cmds[cmd_n] = tbytes[0];
            cmd_n = cmd_n + 1;
            if (tbytes[0] == 8'hC0)
            begin
                ndata = nb / 8 - 1;
                for (int i = 0; i < 16; i++)
                    data[i] = tbytes[i + 1];
            end
            if (tbytes[0] == 8'h42)
            begin
                frame_ok = (cmd_n == 4) && (cmds[0] == 8'h40) && (cmds[1] == 8'hC0)
                           && (cmds[2] == 8'h8F) && (ndata == 16) && (nb == 40);
                if (key7_sent)
                    press_key7 = 1'b0;
                ndata = 0;
                refresh_cnt = refresh_cnt + 1;
                -> refresh_done;
            end
            @(posedge clk);
            pnl_oe <= 1'b0;
        end
    end

    // ----------------------------------------
    // Checker
    // ----------------------------------------

    always
    begin : compare
        logic [15:0][7:0] exp;
        @(refresh_done);
        checks++;
        assert (frame_ok)
        else
        begin
            errors++;
            $display("Refresh %0d has a wrong command sequence or byte count", refresh_cnt);
        end
        if (check_en)
        begin
            exp = expected_panel(exp_keys, exp_sample);
            for (int i = 0; i < 15; i++)
            begin
                checks++;
                assert (data[i] === exp[i])
                else
                begin
                    errors++;
                    $display("** Error: panel_byte[%0d] = 0x%h, expected 0x%h", i, data[i], exp[i]);
                end
            end
            if (check_led)
            begin
                checks++;
                assert (led === ~exp_keys[5:0])
                else
                begin
                    errors++;
                    $display("** Error: led = 0x%h, expected 0x%h", led, ~exp_keys[5:0]);
                end
            end
        end
        led7_hist = {led7_hist[2:0], data[15][0]};
        hb_n = hb_en ? hb_n + 1 : 0;
        if (hb_n >= 4)
        begin
            checks++;
            assert (led7_hist != 4'b0000 && led7_hist != 4'b1111)   // Window spans a tick
            else
            begin
                errors++;
                $display("Panel LED 7 did not toggle over four refreshes");
            end
        end
    end

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    task automatic report_timeout(input string what);
        tm_state_t st;
        st = dut_i.i_tm1638.state;
        timed_out = 1'b1;
        $display("Timeout waiting for %s, panel controller in %s", what, st.name());
    endtask

    task automatic wait_refreshes(input int n);
        int target;
        int cyc;
        target = refresh_cnt + n;
        cyc = 0;
        while (refresh_cnt < target && !timed_out)
        begin
            @(posedge clk);
            cyc++;
            if (cyc > n * 6000)
                report_timeout("a panel refresh");
        end
    endtask

    task automatic apply_pattern();
        logic [23:0] s;
        s = 24'($urandom);
        if (s == '0)
            s = 24'h1;
        cur_sample = s;
        pkeys = 7'($urandom);
        exp_keys = pkeys;
        exp_sample = s;
        wait_refreshes(3);                   // Sample, key read and snapshot settle
        check_en = 1'b1;
        wait_refreshes(2);
        check_en = 1'b0;
    endtask

    initial
    begin : stimulus
        int cyc;
        void'($urandom(11358));
        key = 2'b01;                         // key[1] low holds reset
        uart_rx = 1'b1;
        mic_sd = 1'b0;
        pnl_oe = 1'b0;
        pnl_bit = 1'b0;
        cur_sample = '0;
        pkeys = '0;
        press_key7 = 1'b0;
        key7_sent = 1'b0;
        prev_ws = 1'b0;
        k = 40;
        nb = 0;
        cmd_n = 0;
        ndata = 0;
        frame_ok = 1'b0;
        refresh_cnt = 0;
        hb_n = 0;
        led7_hist = '0;
        check_en = 1'b0;
        check_led = 1'b1;
        hb_en = 1'b0;
        timed_out = 1'b0;
        checks = 0;
        errors = 0;
        exp_keys = '0;
        exp_sample = '0;
        repeat (4) @(posedge clk);
        key <= 2'b11;
        repeat (3) @(posedge clk);
        @(negedge clk);
        compare_value("sio_stb", gpio[14], 1'b1);
        compare_value("sio_clk", gpio[15], 1'b1);
        compare_value("sio_data", gpio[16], 1'b1);             // Released, pulled up
        compare_value("uart_tx", uart_tx, 1'b1);
        compare_value("mic_lr", gpio[18], 1'b0);
        compare_value("mic_gnd", gpio[21], 1'b0);
        compare_value("mic_vdd", gpio[22], 1'b1);
        compare_value("gpio[13:0]", gpio[13:0], 14'h3FFF);     // Unused pins released
        hb_en = 1'b1;
        for (int iter = 0; iter < 6; iter++)
            apply_pattern();
        hb_en = 1'b0;

        // Panel key 7 resets the design and digits fall back to zero codes
        press_key7 = 1'b1;
        cyc = 0;
        while (press_key7 && !timed_out)
        begin
            @(posedge clk);
            cyc++;
            if (cyc > 15000)
                report_timeout("the panel key 7 read");
        end
        exp_keys = '0;
        exp_sample = '0;
        check_led = 1'b0;
        check_en = 1'b1;
        wait_refreshes(1);
        check_en = 1'b0;
        check_led = 1'b1;
        apply_pattern();

        $display("Checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen
#(
    parameter real period_ns = 40.0
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(period_ns / 2.0) clk = ~clk;   // Free-running system clock
    end

endmodule

`default_nettype wire
